// File: issue_consts.svh
// ----------------------------------------
// issue stage widths and counts
// register file, scoreboard and commit
// ----------------------------------------
`ifndef ISSUE_CONSTS_SVH
`define ISSUE_CONSTS_SVH

// operand and register width
`define ISSUE_XLEN 32

// register address width and register count
`define ISSUE_REG_ADDR_BITS 5
`define ISSUE_NR_REGS 32

// scoreboard transaction id width
`define ISSUE_TRANS_ID_BITS 3

// commit write ports into the register file
`define ISSUE_NR_COMMIT_PORTS 2

`endif

// File: issue_pkg.sv
// ----------------------------------------
// issue stage types
// functional units, operations, decoded
// instruction and execute bundle
// ----------------------------------------
`include "issue_consts.svh"

package issue_pkg;

    // functional unit an instruction is steered to
    // NONE must stay zero, the execute register resets to it
    typedef enum logic [2:0] {
        NONE,
        LOAD,
        STORE,
        ALU,
        CTRL_FLOW,
        MULT,
        CSR
    } fu_e;

    // operation code, passed through to the unit untouched
    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND_OP,
        OR_OP,
        XOR_OP,
        SLL,
        SRL,
        MUL_OP,
        LW,
        SW,
        BEQ,
        CSRRW
    } fu_op_e;

    // decoded instruction from the scoreboard
    typedef struct packed {
        logic [`ISSUE_XLEN-1:0]          pc;
        logic [`ISSUE_TRANS_ID_BITS-1:0] trans_id;
        fu_e                             fu;
        fu_op_e                          op;
        logic [`ISSUE_REG_ADDR_BITS-1:0] rs1;
        logic [`ISSUE_REG_ADDR_BITS-1:0] rs2;
        logic [`ISSUE_REG_ADDR_BITS-1:0] rd;
        // immediate value
        logic [`ISSUE_XLEN-1:0]          result;
        logic                            use_imm;
        logic                            use_pc;
        // instruction already carries an exception
        logic                            ex_valid;
    } issue_instr_t;

    // operand bundle handed to execute
    typedef struct packed {
        fu_e                             fu;
        fu_op_e                          op;
        logic [`ISSUE_XLEN-1:0]          operand_a;
        logic [`ISSUE_XLEN-1:0]          operand_b;
        logic [`ISSUE_XLEN-1:0]          imm;
        logic [`ISSUE_TRANS_ID_BITS-1:0] trans_id;
    } fu_data_t;

endpackage

// File: issue_ifs.sv
// ----------------------------------------
// issue stage internal interfaces
// hazard decision and register read port
// ----------------------------------------
`timescale 1ns/1ps
`include "issue_consts.svh"

// hazard decision for the instruction at the issue port
// all members settle within the cycle
interface hazard_if;
    // take the scoreboard value for rs1 / rs2
    logic forward_rs1;
    logic forward_rs2;
    // some source operand is pending and cannot be forwarded
    logic stall;
    // no write-after-write conflict on rd
    logic rd_free;

    modport source (
        output forward_rs1,
        output forward_rs2,
        output stall,
        output rd_free
    );

    modport sink (
        input forward_rs1,
        input forward_rs2,
        input stall,
        input rd_free
    );
endinterface

// two combinational read ports of the integer register file
// addresses come straight from the incoming rs1 / rs2
interface read_port_if;
    logic [`ISSUE_REG_ADDR_BITS-1:0] raddr_a;
    logic [`ISSUE_REG_ADDR_BITS-1:0] raddr_b;
    logic [`ISSUE_XLEN-1:0]          rdata_a;
    logic [`ISSUE_XLEN-1:0]          rdata_b;

    modport regfile (
        input  raddr_a,
        input  raddr_b,
        output rdata_a,
        output rdata_b
    );

    // the consumer only sees the data
    modport reader (
        input rdata_a,
        input rdata_b
    );
endinterface

// File: hazard_check.sv
// ----------------------------------------
// hazard check for the issue stage
// clobber lookup, forward or stall, and
// write-after-write check on rd
// ----------------------------------------
`timescale 1ns/1ps
`include "issue_consts.svh"

module hazard_check import issue_pkg::*; (
    // clock and reset, sampled only by bound checks
    input  logic                                   clk_i,
    input  logic                                   rst_ni,
    // instruction at the issue port
    input  issue_instr_t                           issue_instr_i,
    // pending writer per register
    input  fu_e [`ISSUE_NR_REGS-1:0]               rd_clobber_i,
    // scoreboard has the operand value ready
    input  logic                                   fwd_rs1_valid_i,
    input  logic                                   fwd_rs2_valid_i,
    // commit ports, only address and enable matter here
    input  logic [`ISSUE_NR_COMMIT_PORTS-1:0][`ISSUE_REG_ADDR_BITS-1:0] commit_waddr_i,
    input  logic [`ISSUE_NR_COMMIT_PORTS-1:0]      commit_we_i,
    hazard_if.source                               haz
);

    fu_e  rs1_clobber;
    fu_e  rs2_clobber;
    logic rd_commit_hit;

    assign rs1_clobber = rd_clobber_i[issue_instr_i.rs1];
    assign rs2_clobber = rd_clobber_i[issue_instr_i.rs2];

    // ----------------------------------------
    // source operands
    // ----------------------------------------
    // a clobbered source is pending; it can be forwarded when the
    // scoreboard holds the value, except behind a CSR writer whose
    // result only shows up through the register file
    always_comb begin : source_check
        haz.forward_rs1 = 1'b0;
        haz.forward_rs2 = 1'b0;
        haz.stall       = 1'b0;

        if (rs1_clobber != NONE) begin
            if (fwd_rs1_valid_i && rs1_clobber != CSR) begin
                haz.forward_rs1 = 1'b1;
            end else begin
                haz.stall = 1'b1;
            end
        end

        if (rs2_clobber != NONE) begin
            if (fwd_rs2_valid_i && rs2_clobber != CSR) begin
                haz.forward_rs2 = 1'b1;
            end else begin
                haz.stall = 1'b1;
            end
        end
    end

    // ----------------------------------------
    // write after write
    // ----------------------------------------
    // a commit to rd in this cycle retires the older writer
    always_comb begin : rd_commit
        rd_commit_hit = 1'b0;
        for (int i = 0; i < `ISSUE_NR_COMMIT_PORTS; i++) begin
            if (commit_we_i[i] && commit_waddr_i[i] == issue_instr_i.rd) begin
                rd_commit_hit = 1'b1;
            end
        end
    end

    assign haz.rd_free = (rd_clobber_i[issue_instr_i.rd] == NONE) || rd_commit_hit;

endmodule

// File: int_regfile.sv
// ----------------------------------------
// integer register file
// 32 entries, two reads, commit writes
// ----------------------------------------
`timescale 1ns/1ps
`include "issue_consts.svh"

module int_regfile (
    input  logic                                   clk_i,
    input  logic                                   rst_ni,
    read_port_if.regfile                           rd,
    // commit write ports
    input  logic [`ISSUE_NR_COMMIT_PORTS-1:0][`ISSUE_REG_ADDR_BITS-1:0] commit_waddr_i,
    input  logic [`ISSUE_NR_COMMIT_PORTS-1:0][`ISSUE_XLEN-1:0]          commit_wdata_i,
    input  logic [`ISSUE_NR_COMMIT_PORTS-1:0]      commit_we_i
);

    logic [`ISSUE_XLEN-1:0] mem_q [`ISSUE_NR_REGS];

    // writes land at the edge
    // ports are walked in order, so a higher port wins on equal addresses
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mem_q <= '{default: '0};
        end else begin
            for (int i = 0; i < `ISSUE_NR_COMMIT_PORTS; i++) begin
                if (commit_we_i[i]) begin
                    mem_q[commit_waddr_i[i]] <= commit_wdata_i[i];
                end
            end
        end
    end

    // combinational reads
    // x0 is hardwired, whatever was written there
    assign rd.rdata_a = (rd.raddr_a == '0) ? '0 : mem_q[rd.raddr_a];
    assign rd.rdata_b = (rd.raddr_b == '0) ? '0 : mem_q[rd.raddr_b];

endmodule

// File: operand_issue.sv
// ----------------------------------------
// operand select and issue
// operand mux, acknowledge, unit valids
// and the execute registers
// ----------------------------------------
`timescale 1ns/1ps
`include "issue_consts.svh"

module operand_issue import issue_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   flush_i,
    // issue handshake
    input  issue_instr_t           issue_instr_i,
    input  logic                   issue_valid_i,
    output logic                   issue_ack_o,
    // hazard decision and register values
    hazard_if.sink                 haz,
    read_port_if.reader            rd,
    // scoreboard forwarded values
    input  logic [`ISSUE_XLEN-1:0] fwd_rs1_i,
    input  logic [`ISSUE_XLEN-1:0] fwd_rs2_i,
    // unit readiness
    input  logic                   flu_ready_i,
    input  logic                   lsu_ready_i,
    // to execute
    output fu_data_t               fu_data_o,
    output logic [`ISSUE_XLEN-1:0] pc_o,
    output logic                   alu_valid_o,
    output logic                   branch_valid_o,
    output logic                   lsu_valid_o,
    output logic                   mult_valid_o,
    output logic                   csr_valid_o
);

    logic                   fu_busy;
    logic                   issue_fire;
    logic [`ISSUE_XLEN-1:0] operand_a_d;
    logic [`ISSUE_XLEN-1:0] operand_b_d;
    fu_data_t               fu_data_d;

    // ----------------------------------------
    // operand mux
    // ----------------------------------------
    always_comb begin : operand_select
        // register file by default, scoreboard when forwarded
        operand_a_d = haz.forward_rs1 ? fwd_rs1_i : rd.rdata_a;
        operand_b_d = haz.forward_rs2 ? fwd_rs2_i : rd.rdata_b;
        // pc replaces operand a, e.g. auipc and jal
        if (issue_instr_i.use_pc) begin
            operand_a_d = issue_instr_i.pc;
        end
        // stores and branches keep rs2, the immediate rides in imm
        if (issue_instr_i.use_imm && issue_instr_i.fu != STORE
                && issue_instr_i.fu != CTRL_FLOW) begin
            operand_b_d = issue_instr_i.result;
        end
    end

    assign fu_data_d.fu        = issue_instr_i.fu;
    assign fu_data_d.op        = issue_instr_i.op;
    assign fu_data_d.operand_a = operand_a_d;
    assign fu_data_d.operand_b = operand_b_d;
    assign fu_data_d.imm       = issue_instr_i.result;
    assign fu_data_d.trans_id  = issue_instr_i.trans_id;

    // ----------------------------------------
    // acknowledge
    // ----------------------------------------
    // fixed latency units share flu_ready_i
    always_comb begin : unit_busy
        unique case (issue_instr_i.fu)
            ALU, CTRL_FLOW, MULT, CSR: fu_busy = ~flu_ready_i;
            LOAD, STORE:               fu_busy = ~lsu_ready_i;
            default:                   fu_busy = 1'b0;
        endcase
    end

    always_comb begin : ack_logic
        issue_ack_o = 1'b0;
        if (issue_valid_i) begin
            if (!haz.stall && !fu_busy && haz.rd_free) begin
                issue_ack_o = 1'b1;
            end
            // excepted or unit-less instructions start nothing, let them pass
            if (issue_instr_i.ex_valid || issue_instr_i.fu == NONE) begin
                issue_ack_o = 1'b1;
            end
        end
        // the multiplier result bus is busy next cycle, only another
        // multiply may follow
        if (mult_valid_o && issue_instr_i.fu != MULT) begin
            issue_ack_o = 1'b0;
        end
    end

    assign issue_fire = issue_valid_i && issue_ack_o;

    // ----------------------------------------
    // execute registers
    // ----------------------------------------
    // bundle is held until the next accepted instruction
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fu_data_o <= '0;
            pc_o      <= '0;
        end else if (issue_fire) begin
            fu_data_o <= fu_data_d;
            pc_o      <= issue_instr_i.pc;
        end
    end

    // one-hot unit valid, one cycle after acceptance
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            alu_valid_o    <= 1'b0;
            branch_valid_o <= 1'b0;
            lsu_valid_o    <= 1'b0;
            mult_valid_o   <= 1'b0;
            csr_valid_o    <= 1'b0;
        end else begin
            alu_valid_o    <= 1'b0;
            branch_valid_o <= 1'b0;
            lsu_valid_o    <= 1'b0;
            mult_valid_o   <= 1'b0;
            csr_valid_o    <= 1'b0;
            // flush wins over a fresh issue
            if (issue_fire && !issue_instr_i.ex_valid && !flush_i) begin
                unique case (issue_instr_i.fu)
                    ALU:         alu_valid_o    <= 1'b1;
                    CTRL_FLOW:   branch_valid_o <= 1'b1;
                    LOAD, STORE: lsu_valid_o    <= 1'b1;
                    MULT:        mult_valid_o   <= 1'b1;
                    CSR:         csr_valid_o    <= 1'b1;
                    default: ;
                endcase
            end
        end
    end

endmodule

// File: issue_stage.sv
// ----------------------------------------
// issue and operand-read stage, top level
// hazard check, register file, operand issue
// ----------------------------------------
`timescale 1ns/1ps
`include "issue_consts.svh"

module issue_stage import issue_pkg::*; (
    input  logic                                   clk_i,
    input  logic                                   rst_ni,
    input  logic                                   flush_i,
    // issue handshake
    input  issue_instr_t                           issue_instr_i,
    input  logic                                   issue_valid_i,
    output logic                                   issue_ack_o,
    // scoreboard clobber list and forwarding
    input  fu_e [`ISSUE_NR_REGS-1:0]               rd_clobber_i,
    input  logic [`ISSUE_XLEN-1:0]                 fwd_rs1_i,
    input  logic                                   fwd_rs1_valid_i,
    input  logic [`ISSUE_XLEN-1:0]                 fwd_rs2_i,
    input  logic                                   fwd_rs2_valid_i,
    // unit readiness
    input  logic                                   flu_ready_i,
    input  logic                                   lsu_ready_i,
    // commit write ports
    input  logic [`ISSUE_NR_COMMIT_PORTS-1:0][`ISSUE_REG_ADDR_BITS-1:0] commit_waddr_i,
    input  logic [`ISSUE_NR_COMMIT_PORTS-1:0][`ISSUE_XLEN-1:0]          commit_wdata_i,
    input  logic [`ISSUE_NR_COMMIT_PORTS-1:0]      commit_we_i,
    // to execute
    output fu_data_t                               fu_data_o,
    output logic [`ISSUE_XLEN-1:0]                 pc_o,
    output logic                                   alu_valid_o,
    output logic                                   branch_valid_o,
    output logic                                   lsu_valid_o,
    output logic                                   mult_valid_o,
    output logic                                   csr_valid_o
);

    hazard_if    haz_if ();
    read_port_if rd_if ();

    // register reads follow the incoming sources
    assign rd_if.raddr_a = issue_instr_i.rs1;
    assign rd_if.raddr_b = issue_instr_i.rs2;

    // hazard check and register read run side by side
    hazard_check u_hazard_check (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .issue_instr_i   (issue_instr_i),
        .rd_clobber_i    (rd_clobber_i),
        .fwd_rs1_valid_i (fwd_rs1_valid_i),
        .fwd_rs2_valid_i (fwd_rs2_valid_i),
        .commit_waddr_i  (commit_waddr_i),
        .commit_we_i     (commit_we_i),
        .haz             (haz_if.source)
    );

    int_regfile u_int_regfile (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .rd             (rd_if.regfile),
        .commit_waddr_i (commit_waddr_i),
        .commit_wdata_i (commit_wdata_i),
        .commit_we_i    (commit_we_i)
    );

    operand_issue u_operand_issue (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .flush_i        (flush_i),
        .issue_instr_i  (issue_instr_i),
        .issue_valid_i  (issue_valid_i),
        .issue_ack_o    (issue_ack_o),
        .haz            (haz_if.sink),
        .rd             (rd_if.reader),
        .fwd_rs1_i      (fwd_rs1_i),
        .fwd_rs2_i      (fwd_rs2_i),
        .flu_ready_i    (flu_ready_i),
        .lsu_ready_i    (lsu_ready_i),
        .fu_data_o      (fu_data_o),
        .pc_o           (pc_o),
        .alu_valid_o    (alu_valid_o),
        .branch_valid_o (branch_valid_o),
        .lsu_valid_o    (lsu_valid_o),
        .mult_valid_o   (mult_valid_o),
        .csr_valid_o    (csr_valid_o)
    );

endmodule

// File: tb_clock_gen.sv
// ----------------------------------------
// testbench clock and reset
// 4 ns period, reset low for 10 cycles
// ----------------------------------------
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // release just after an edge, like the rest of the stimulus
    initial begin
        rst_no = 1'b0;
        repeat (10) @(posedge clk_o);
        #1 rst_no = 1'b1;
    end

endmodule

// File: issue_stage_chk.sv
// ----------------------------------------
// bound checks on the issue stage outputs
// one-hot valids, flush, known operands
// ----------------------------------------
`timescale 1ns/1ps

module issue_stage_chk import issue_pkg::*; (
    input logic     clk_i,
    input logic     rst_ni,
    input logic     flush_i,
    input logic     alu_valid_o,
    input logic     branch_valid_o,
    input logic     lsu_valid_o,
    input logic     mult_valid_o,
    input logic     csr_valid_o,
    input fu_data_t fu_data_o
);

    logic [4:0]  vld;
    int unsigned fail_cnt = 0;

    assign vld = {alu_valid_o, branch_valid_o, lsu_valid_o, mult_valid_o, csr_valid_o};

    // at most one unit starts per cycle
    a_one_valid: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(vld))
        else begin
            $error("more than one unit valid is high");
            fail_cnt++;
        end

    // flush kills whatever was about to start
    a_flush: assert property (@(posedge clk_i) disable iff (!rst_ni) flush_i |=> vld == '0)
        else begin
            $error("unit valid high right after a flush");
            fail_cnt++;
        end

    a_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
            |vld |-> !$isunknown({fu_data_o.operand_a, fu_data_o.operand_b}))
        else begin
            $error("operands unknown while a unit valid is high");
            fail_cnt++;
        end

endmodule

bind issue_stage issue_stage_chk chk_i (.*);

// File: issue_stage_tb.sv
// ----------------------------------------
// issue stage testbench
// stimulus, register model, reference
// function and the comparing process
// ----------------------------------------
`timescale 1ns/1ps
`include "issue_consts.svh"

module issue_stage_tb import issue_pkg::*; ();

    // predicted acknowledge, unit valids {alu, branch, lsu, mult, csr} and bundle
    typedef struct packed {
        logic       ack;
        logic [4:0] vld;
        fu_data_t   data;
    } expect_t;

    logic                                                       clk;
    logic                                                       rst_n;
    logic                                                       flush;
    issue_instr_t                                               instr;
    logic                                                       valid;
    logic                                                       ack;
    fu_e [`ISSUE_NR_REGS-1:0]                                   clobber;
    logic [`ISSUE_XLEN-1:0]                                     fwd1;
    logic [`ISSUE_XLEN-1:0]                                     fwd2;
    logic                                                       fwd1_v;
    logic                                                       fwd2_v;
    logic                                                       flu_rdy;
    logic                                                       lsu_rdy;
    logic [`ISSUE_NR_COMMIT_PORTS-1:0][`ISSUE_REG_ADDR_BITS-1:0] c_addr;
    logic [`ISSUE_NR_COMMIT_PORTS-1:0][`ISSUE_XLEN-1:0]          c_data;
    logic [`ISSUE_NR_COMMIT_PORTS-1:0]                           c_we;
    fu_data_t                                                   fu_data;
    logic [`ISSUE_XLEN-1:0]                                     pc;
    logic [4:0]                                                 vld;
    logic [`ISSUE_XLEN-1:0]                                     regs_m [`ISSUE_NR_REGS];
    logic [4:0]                                                 vld_exp;
    fu_data_t                                                   data_exp;
    logic [`ISSUE_XLEN-1:0]                                     pc_exp;
    logic [31:0]                                                rng_q = 32'd44;
    fu_e                                                        units [6] =
        '{ALU, CTRL_FLOW, LOAD, STORE, MULT, CSR};
    int                                                         errors = 0;
    int                                                         timeouts = 0;

    tb_clock_gen clk_gen_i (.clk_o(clk), .rst_no(rst_n));

    issue_stage dut_i (
        .clk_i(clk), .rst_ni(rst_n), .flush_i(flush), .issue_instr_i(instr),
        .issue_valid_i(valid), .issue_ack_o(ack), .rd_clobber_i(clobber),
        .fwd_rs1_i(fwd1), .fwd_rs1_valid_i(fwd1_v), .fwd_rs2_i(fwd2),
        .fwd_rs2_valid_i(fwd2_v), .flu_ready_i(flu_rdy), .lsu_ready_i(lsu_rdy),
        .commit_waddr_i(c_addr), .commit_wdata_i(c_data), .commit_we_i(c_we),
        .fu_data_o(fu_data), .pc_o(pc), .alu_valid_o(vld[4]), .branch_valid_o(vld[3]),
        .lsu_valid_o(vld[2]), .mult_valid_o(vld[1]), .csr_valid_o(vld[0])
    );

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    function automatic logic [31:0] xorshift32();
        rng_q ^= rng_q << 13;
        rng_q ^= rng_q >> 17;
        rng_q ^= rng_q << 5;
        return rng_q;
    endfunction

    // x0 reads zero whatever was committed to it
    function automatic logic [`ISSUE_XLEN-1:0] reg_val(input logic [4:0] a);
        return (a == '0) ? '0 : regs_m[a];
    endfunction

    function automatic issue_instr_t make_instr(input fu_e fu, input fu_op_e op,
            input logic [4:0] rs1, input logic [4:0] rs2, input logic [4:0] rd);
        issue_instr_t ins;
        ins = '0;
        ins.pc = xorshift32() & 32'hffff_fffc;
        ins.trans_id = 3'(xorshift32());
        ins.result = xorshift32();
        ins.fu = fu;
        ins.op = op;
        ins.rs1 = rs1;
        ins.rs2 = rs2;
        ins.rd = rd;
        return ins;
    endfunction

    // ----------------------------------------
    // reference function
    // ----------------------------------------
    function automatic expect_t predict(input logic mult_now);
        expect_t e;
        fu_e     c1;
        fu_e     c2;
        logic    f1;
        logic    f2;
        logic    stall;
        logic    busy;
        logic    free;
        e = '0;
        c1 = clobber[instr.rs1];
        c2 = clobber[instr.rs2];
        // forward only from a valid scoreboard value of a non-csr writer
        f1 = c1 != NONE && c1 != CSR && fwd1_v;
        f2 = c2 != NONE && c2 != CSR && fwd2_v;
        stall = (c1 != NONE && !f1) || (c2 != NONE && !f2);
        busy = (instr.fu inside {LOAD, STORE}) ? !lsu_rdy : (instr.fu != NONE && !flu_rdy);
        free = clobber[instr.rd] == NONE;
        for (int i = 0; i < `ISSUE_NR_COMMIT_PORTS; i++) begin
            if (c_we[i] && c_addr[i] == instr.rd) free = 1'b1;
        end
        e.ack = valid && ((!stall && !busy && free) || instr.ex_valid || instr.fu == NONE)
                && !(mult_now && instr.fu != MULT);
        e.data.fu = instr.fu;
        e.data.op = instr.op;
        e.data.imm = instr.result;
        e.data.trans_id = instr.trans_id;
        e.data.operand_a = instr.use_pc ? instr.pc : f1 ? fwd1 : reg_val(instr.rs1);
        e.data.operand_b = (instr.use_imm && !(instr.fu inside {STORE, CTRL_FLOW}))
                           ? instr.result : f2 ? fwd2 : reg_val(instr.rs2);
        if (e.ack && !instr.ex_valid && !flush) begin
            case (instr.fu)
                ALU:         e.vld = 5'b10000;
                CTRL_FLOW:   e.vld = 5'b01000;
                LOAD, STORE: e.vld = 5'b00100;
                MULT:        e.vld = 5'b00010;
                CSR:         e.vld = 5'b00001;
                default:     e.vld = 5'b00000;
            endcase
        end
        return e;
    endfunction

    task automatic mismatch(input string what, input logic [127:0] got,
            input logic [127:0] exp);
        errors++;
        $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
    endtask

    // ----------------------------------------
    // comparing process at mid-cycle
    // ----------------------------------------
    always @(negedge clk) begin : compare
        expect_t pred;
        if (!rst_n) begin
            vld_exp = '0;
            data_exp = '0;
            pc_exp = '0;
            for (int i = 0; i < `ISSUE_NR_REGS; i++) regs_m[i] = '0;
        end else begin
            assert (vld === vld_exp) else mismatch("unit valids", vld, vld_exp);
            assert (fu_data === data_exp) else mismatch("fu_data_o", fu_data, data_exp);
            assert (pc === pc_exp) else mismatch("pc_o", pc, pc_exp);
            pred = predict(vld_exp[1]);
            assert (ack === pred.ack) else mismatch("issue_ack_o", ack, pred.ack);
            vld_exp = pred.vld;
            if (pred.ack) begin
                data_exp = pred.data;
                pc_exp = instr.pc;
            end
            // commits land at the coming edge, higher port last
            for (int i = 0; i < `ISSUE_NR_COMMIT_PORTS; i++) begin
                if (c_we[i]) regs_m[c_addr[i]] = c_data[i];
            end
        end
    end

    // ----------------------------------------
    // stimulus tasks
    // ----------------------------------------
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic clear_clobbers();
        for (int i = 0; i < `ISSUE_NR_REGS; i++) clobber[i] = NONE;
    endtask

    // present an instruction without expecting it to pass
    task automatic hold(input issue_instr_t ins, input int cycles);
        instr = ins;
        valid = 1'b1;
        repeat (cycles) next_cycle();
    endtask

    task automatic send(input issue_instr_t ins);
        int n;
        instr = ins;
        valid = 1'b1;
        n = 0;
        @(negedge clk);
        while (ack !== 1'b1 && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (ack !== 1'b1) begin
            timeouts++;
            $display("timeout at %0t: instruction was never acknowledged", $time);
        end
        next_cycle();
        valid = 1'b0;
    endtask

    // ----------------------------------------
    // test sequence
    // ----------------------------------------
    initial begin
        issue_instr_t ins;
        logic [31:0]  r;
        int           n;
        flush = 1'b0;
        instr = '0;
        valid = 1'b0;
        clear_clobbers();
        fwd1 = '0;
        fwd2 = '0;
        fwd1_v = 1'b0;
        fwd2_v = 1'b0;
        flu_rdy = 1'b1;
        lsu_rdy = 1'b1;
        c_addr = '0;
        c_data = '0;
        c_we = '0;
        n = 0;
        while (rst_n !== 1'b1 && n < 50) begin
            @(posedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            timeouts++;
            $display("reset was never released");
        end
        next_cycle();

        // fill all registers, x0 included, then a same-address cycle
        for (int i = 0; i < 17; i++) begin
            c_we = 2'b11;
            c_addr[0] = (i == 16) ? 5'd5 : 5'(i);
            c_addr[1] = (i == 16) ? 5'd5 : 5'(i + 16);
            c_data[0] = xorshift32();
            c_data[1] = xorshift32();
            next_cycle();
        end
        c_we = '0;
        for (int i = 0; i < 16; i++) send(make_instr(ALU, ADD, 5'(i), 5'(31 - i), 5'(i + 1)));

        // forwarding, then stalls behind csr and an invalid forward
        clobber[3] = ALU;
        clobber[9] = LOAD;
        fwd1_v = 1'b1;
        fwd2_v = 1'b1;
        fwd1 = xorshift32();
        fwd2 = xorshift32();
        send(make_instr(ALU, SUB, 5'd3, 5'd9, 5'd12));
        clobber[3] = CSR;
        hold(make_instr(ALU, XOR_OP, 5'd3, 5'd9, 5'd12), 3);
        clobber[3] = NONE;
        send(instr);
        clobber[9] = MULT;
        fwd2_v = 1'b0;
        hold(make_instr(ALU, OR_OP, 5'd1, 5'd9, 5'd13), 3);
        fwd2_v = 1'b1;
        send(instr);
        clear_clobbers();
        fwd1_v = 1'b0;
        fwd2_v = 1'b0;

        // pc and immediate replacement on alu, branch, load and store
        for (int i = 0; i < 4; i++) begin
            ins = make_instr(units[i], ADD, 5'd4, 5'd6, 5'd8);
            ins.use_pc = 1'b1;
            ins.use_imm = 1'b1;
            send(ins);
        end

        // write after write freed by a commit in the same cycle
        clobber[7] = ALU;
        hold(make_instr(ALU, AND_OP, 5'd1, 5'd2, 5'd7), 3);
        c_we = 2'b10;
        c_addr[1] = 5'd7;
        c_data[1] = xorshift32();
        send(instr);
        c_we = '0;
        clear_clobbers();

        // readiness blocks only the matching units
        flu_rdy = 1'b0;
        send(make_instr(LOAD, LW, 5'd2, 5'd0, 5'd10));
        hold(make_instr(ALU, SLL, 5'd2, 5'd3, 5'd11), 2);
        flu_rdy = 1'b1;
        send(instr);
        lsu_rdy = 1'b0;
        send(make_instr(CSR, CSRRW, 5'd4, 5'd0, 5'd14));
        hold(make_instr(STORE, SW, 5'd5, 5'd6, 5'd0), 2);
        lsu_rdy = 1'b1;
        send(instr);

        // every unit, then unit-less and excepted with nothing ready
        foreach (units[k]) send(make_instr(units[k], ADD, 5'(k + 1), 5'(k + 2), 5'(k + 3)));
        flu_rdy = 1'b0;
        lsu_rdy = 1'b0;
        send(make_instr(NONE, ADD, 5'd1, 5'd2, 5'd3));
        ins = make_instr(ALU, ADD, 5'd1, 5'd2, 5'd3);
        ins.ex_valid = 1'b1;
        send(ins);
        flu_rdy = 1'b1;
        lsu_rdy = 1'b1;

        // multiply blocks a following non-multiply for a cycle
        send(make_instr(MULT, MUL_OP, 5'd8, 5'd9, 5'd15));
        send(make_instr(ALU, SRL, 5'd8, 5'd9, 5'd16));
        flush = 1'b1;
        send(make_instr(ALU, ADD, 5'd10, 5'd11, 5'd17));
        flush = 1'b0;

        // random mix with x0 and the immediate thrown in
        for (int k = 0; k < 20; k++) begin
            r = xorshift32();
            ins = make_instr(units[r % 6], ADD, 5'(r >> 3), 5'(r >> 8), 5'(r >> 13));
            ins.use_imm = r[20];
            send(ins);
        end
        next_cycle();
        next_cycle();

        n = dut_i.chk_i.fail_cnt;
        $display("value errors %0d, timeouts %0d, assertion failures %0d",
                 errors, timeouts, n);
        if (errors == 0 && timeouts == 0 && n == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: issue_stage.f
+incdir+.
issue_pkg.sv
issue_ifs.sv
hazard_check.sv
int_regfile.sv
operand_issue.sv
issue_stage.sv
tb_clock_gen.sv
issue_stage_chk.sv
issue_stage_tb.sv
